// File: source/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddiu = 6'h09,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functE;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormatS;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFormatS;

	// Register and immediate views of one instruction word
	typedef union packed {
		rFormatS r;
		iFormatS i;
	} instrU;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSlt,
		aluLui, aluLoad, aluStore, aluBranch, aluJump
	} aluOpE;

	typedef struct packed {
		logic [31:0] addr;     // Word aligned
		logic        write;
		logic [31:0] wdata;
	} busReqS;

	typedef struct packed {
		aluOpE       op;
		logic [31:0] result;   // ALU value or memory address
		logic [4:0]  dest;
		logic        regWrite;
		logic        memRead;
		logic        memWrite;
		logic        taken;
		logic [31:0] target;
	} execS;

endpackage

`default_nettype wire

// File: source/fetchUnit.sv
`default_nettype none

module fetchUnit #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input  logic            clk,
	input  logic            arstN,
	input  logic            redirect,
	input  logic [31:0]     target,
	input  logic            take,
	output mipsPkg::busReqS req,
	output logic            reqValid,
	input  logic            ack,
	input  logic [31:0]     rdata,
	output mipsPkg::instrU  instr,
	output logic [31:0]     instrPc,
	output logic            instrValid
);
	typedef enum logic [1:0] {fsIdle, fsReq, fsRelease} fetchStateE;

	fetchStateE  state;
	logic [31:0] pc;        // Word in flight or next to fetch
	logic [31:0] redirPc;
	logic        stale;     // Word in flight belongs to the old path
	logic        go;        // Fetch owed once the bus side is idle
	logic        launch;

	assign launch   = (state == fsIdle) && (go || take);
	assign req      = '{addr: pc, write: 1'b0, wdata: 32'd0};
	assign reqValid = (state == fsReq);

	////////////////////////////////////////////////////////////////////////////
	// Four-phase request and PC update
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state      <= fsIdle;
			pc         <= resetPc;
			stale      <= 1'b0;
			go         <= 1'b1;    // First fetch right out of reset
			instrValid <= 1'b0;
		end else begin
			if (take) begin
				instrValid <= 1'b0;
			end
			if (redirect) begin
				stale <= 1'b1;
			end
			case (state)
				fsIdle: begin
					if (launch) begin
						state <= fsReq;
						go    <= 1'b0;
					end
				end
				fsReq: begin
					if (ack) begin
						state <= fsRelease;
						if (stale) begin
							// Discard and restart at the branch target
							pc    <= redirPc;
							stale <= 1'b0;
							go    <= 1'b1;
						end else begin
							pc         <= pc + 32'd4;
							instrValid <= 1'b1;
						end
					end
				end
				default: begin
					if (take) begin
						go <= 1'b1;
					end
					if (!ack) begin
						state <= fsIdle;    // Ack fell, handshake closed
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (redirect) begin
			redirPc <= target;
		end
		if (state == fsReq && ack && !stale) begin
			instr   <= rdata;
			instrPc <= pc;
		end
	end

endmodule

`default_nettype wire

// File: source/loadStoreUnit.sv
`default_nettype none

module loadStoreUnit (
	input  logic            clk,
	input  logic            arstN,
	input  logic            start,
	input  logic [31:0]     addr,
	input  logic            write,
	input  logic [31:0]     wdata,
	output mipsPkg::busReqS req,
	output logic            reqValid,
	input  logic            ack,
	input  logic [31:0]     rdata,
	output logic [31:0]     loadData,
	output logic            done
);
	typedef enum logic [1:0] {lsIdle, lsReq, lsRelease} lsStateE;

	lsStateE state;

	assign reqValid = (state == lsReq);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= lsIdle;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				lsIdle: begin
					if (start) begin
						state <= lsReq;
					end
				end
				lsReq: begin
					if (ack) begin
						state <= lsRelease;
					end
				end
				default: begin
					if (!ack) begin
						state <= lsIdle;
						done  <= 1'b1;    // One cycle pulse
					end
				end
			endcase
		end
	end

	// Request held stable for the whole handshake
	always_ff @(posedge clk) begin
		if (state == lsIdle && start) begin
			req <= '{addr: addr, write: write, wdata: wdata};
		end
		if (state == lsReq && ack && !req.write) begin
			loadData <= rdata;
		end
	end

endmodule

`default_nettype wire

// File: source/memArbiter.sv
`default_nettype none

module memArbiter (
	input  logic            clk,
	input  logic            arstN,
	input  mipsPkg::busReqS fetchReq,
	input  logic            fetchValid,
	output logic            fetchAck,
	input  mipsPkg::busReqS lsuReq,
	input  logic            lsuValid,
	output logic            lsuAck,
	output mipsPkg::busReqS busReq,
	output logic            busReqValid,
	input  logic            busAck
);
	logic busy;        // A transaction owns the bus
	logic grantLsu;
	logic pickLsu;

	// Load/store wins when both ask on an idle bus
	assign pickLsu = busy ? grantLsu : lsuValid;

	assign busReq      = pickLsu ? lsuReq : fetchReq;
	assign busReqValid = pickLsu ? lsuValid : fetchValid;
	assign lsuAck      = busAck & pickLsu;
	assign fetchAck    = busAck & ~pickLsu;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy     <= 1'b0;
			grantLsu <= 1'b0;
		end else if (!busy) begin
			if (busReqValid) begin
				busy     <= 1'b1;
				grantLsu <= pickLsu;
			end
		end else if (!busReqValid && !busAck) begin
			busy <= 1'b0;    // Granted ack has fallen
		end
	end

endmodule

`default_nettype wire

// File: source/regFile.sv
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rs,
	input  logic [4:0]  rt,
	output logic [31:0] rsData,
	output logic [31:0] rtData,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd
);
	logic [31:0] regs [32];

	// Register 0 is hardwired to zero
	assign rsData = (rs == 5'd0) ? 32'd0 : regs[rs];
	assign rtData = (rt == 5'd0) ? 32'd0 : regs[rt];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= 32'd0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

endmodule

`default_nettype wire

// File: source/execUnit.sv
`default_nettype none

module execUnit (
	input  mipsPkg::instrU instr,
	input  logic [31:0]    pc,
	input  logic [31:0]    rsData,
	input  logic [31:0]    rtData,
	output mipsPkg::execS  exec
);
	import mipsPkg::*;

	logic [31:0] pcNext;
	logic [31:0] immSext;
	logic [31:0] immZext;
	logic [31:0] opB;
	aluOpE       op;

	assign pcNext  = pc + 32'd4;
	assign immSext = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign immZext = {16'd0, instr.i.imm};

	always_comb begin
		op            = aluAdd;
		opB           = immSext;
		exec.dest     = instr.i.rt;
		exec.regWrite = 1'b0;
		exec.memRead  = 1'b0;
		exec.memWrite = 1'b0;
		exec.taken    = 1'b0;
		exec.target   = pcNext + {immSext[29:0], 2'b00};    // Branch offset in words
		case (opcodeE'(instr.i.opcode))
			opRtype: begin
				opB           = rtData;
				exec.dest     = instr.r.rd;
				exec.regWrite = 1'b1;
				case (functE'(instr.r.funct))
					fnAddu:  op = aluAdd;
					fnSubu:  op = aluSub;
					fnAnd:   op = aluAnd;
					fnOr:    op = aluOr;
					fnSlt:   op = aluSlt;
					default: exec.regWrite = 1'b0;    // Unknown funct retires as nop
				endcase
			end
			opAddiu: exec.regWrite = 1'b1;
			opOri: begin
				op            = aluOr;
				opB           = immZext;
				exec.regWrite = 1'b1;
			end
			opLui: begin
				op            = aluLui;
				exec.regWrite = 1'b1;
			end
			opLw: begin
				op            = aluLoad;
				exec.regWrite = 1'b1;
				exec.memRead  = 1'b1;
			end
			opSw: begin
				op            = aluStore;
				exec.memWrite = 1'b1;
			end
			opBeq: begin
				op         = aluBranch;
				exec.taken = (rsData == rtData);
			end
			opBne: begin
				op         = aluBranch;
				exec.taken = (rsData != rtData);
			end
			opJ: begin
				op          = aluJump;
				exec.taken  = 1'b1;
				// Index sits in the low 26 bits of the word
				exec.target = {pcNext[31:28], instr.i[25:0], 2'b00};
			end
			default: ;
		endcase

		case (op)
			aluSub:  exec.result = rsData - opB;
			aluAnd:  exec.result = rsData & opB;
			aluOr:   exec.result = rsData | opB;
			aluSlt:  exec.result = {31'd0, $signed(rsData) < $signed(opB)};
			aluLui:  exec.result = {instr.i.imm, 16'd0};
			default: exec.result = rsData + opB;    // Also the load/store address
		endcase
		exec.op = op;
	end

endmodule

`default_nettype wire

// File: source/mips.sv
`default_nettype none

module mips #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input  logic            clk,
	input  logic            arstN,
	output mipsPkg::busReqS busReq,
	output logic            busReqValid,
	input  logic            busAck,
	input  logic [31:0]     busRdata,
	output logic            grfWe,
	output logic [4:0]      grfAddr,
	output logic [31:0]     grfWdata,
	output logic [31:0]     wbInstAddr
);
	import mipsPkg::*;

	typedef enum logic [1:0] {sIdle, sMem, sWb} seqStateE;

	seqStateE    state;
	instrU       instr;
	logic [31:0] instrPc;
	logic        instrValid;
	execS        exec;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic        accept;
	logic        isMem;
	logic        redirect;
	logic        lsuStart;
	busReqS      fetchReq;
	logic        fetchValid;
	logic        fetchAck;
	busReqS      lsuReq;
	logic        lsuValid;
	logic        lsuAck;
	logic        lsuDone;
	logic [31:0] loadData;

	// Retiring instruction held until write-back
	logic [31:0] curPc;
	logic [31:0] curResult;
	logic [4:0]  curDest;
	logic        curRegWrite;
	logic        curMemRead;

	fetchUnit #(.resetPc(resetPc)) fetch (
		.clk(clk), .arstN(arstN),
		.redirect(redirect), .target(exec.target), .take(accept),
		.req(fetchReq), .reqValid(fetchValid), .ack(fetchAck), .rdata(busRdata),
		.instr(instr), .instrPc(instrPc), .instrValid(instrValid)
	);

	loadStoreUnit lsu (
		.clk(clk), .arstN(arstN),
		.start(lsuStart), .addr(exec.result), .write(exec.memWrite), .wdata(rtData),
		.req(lsuReq), .reqValid(lsuValid), .ack(lsuAck), .rdata(busRdata),
		.loadData(loadData), .done(lsuDone)
	);

	memArbiter arb (
		.clk(clk), .arstN(arstN),
		.fetchReq(fetchReq), .fetchValid(fetchValid), .fetchAck(fetchAck),
		.lsuReq(lsuReq), .lsuValid(lsuValid), .lsuAck(lsuAck),
		.busReq(busReq), .busReqValid(busReqValid), .busAck(busAck)
	);

	regFile grf (
		.clk(clk), .arstN(arstN),
		.rs(instr.r.rs), .rt(instr.r.rt), .rsData(rsData), .rtData(rtData),
		.we(grfWe), .wa(grfAddr), .wd(grfWdata)
	);

	execUnit exu (
		.instr(instr), .pc(instrPc), .rsData(rsData), .rtData(rtData), .exec(exec)
	);

	////////////////////////////////////////////////////////////////////////////
	// Retire sequencer
	assign accept   = (state == sIdle) && instrValid;
	assign isMem    = (exec.op == aluLoad) || (exec.op == aluStore);
	assign redirect = accept && exec.taken;
	assign lsuStart = accept && isMem;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state      <= sIdle;
			wbInstAddr <= 32'd0;
		end else begin
			case (state)
				sIdle: begin
					if (lsuStart) begin
						state <= sMem;
					end else if (accept) begin
						state      <= sWb;
						wbInstAddr <= instrPc;
					end
				end
				sMem: begin
					if (lsuDone) begin
						state      <= sWb;
						wbInstAddr <= curPc;
					end
				end
				default: state <= sIdle;    // Write-back lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			curPc       <= instrPc;
			curResult   <= exec.result;
			curDest     <= exec.dest;
			curRegWrite <= exec.regWrite;
			curMemRead  <= exec.memRead;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Write-back and trace
	assign grfWe    = (state == sWb) && curRegWrite && (curDest != 5'd0);
	assign grfAddr  = curDest;
	assign grfWdata = curMemRead ? loadData : curResult;

endmodule

`default_nettype wire

// File: verif/mipsBus_props.sv
`default_nettype none

module mipsBusProps (
	input logic            clk,
	input logic            arstN,
	input mipsPkg::busReqS busReq,
	input logic            busReqValid,
	input logic            busAck,
	input logic            fetchValid,
	input logic            fetchAck,
	input logic            lsuValid,
	input logic            lsuAck,
	input logic            pickLsu
);
	reqStable: assert property (@(posedge clk) disable iff (!arstN)
		busReqValid && !busAck |=> $stable(busReq))
		else $error("Bus request changed while waiting for ack");

	fetchAckValid: assert property (@(posedge clk) disable iff (!arstN)
		$rose(fetchAck) |-> fetchValid)
		else $error("Fetch ack raised with no fetch request");

	lsuAckValid: assert property (@(posedge clk) disable iff (!arstN)
		$rose(lsuAck) |-> lsuValid)
		else $error("Load/store ack raised with no load/store request");

	validHeld: assert property (@(posedge clk) disable iff (!arstN)
		busReqValid && !busAck |=> busReqValid)
		else $error("Valid dropped before ack");

	// Grant locked for the whole handshake
	grantHeld: assert property (@(posedge clk) disable iff (!arstN)
		busReqValid || busAck |=> $stable(pickLsu))
		else $error("Grant switched during a transaction");

endmodule

bind memArbiter mipsBusProps busProps (
	.clk(clk), .arstN(arstN), .busReq(busReq), .busReqValid(busReqValid),
	.busAck(busAck), .fetchValid(fetchValid), .fetchAck(fetchAck),
	.lsuValid(lsuValid), .lsuAck(lsuAck), .pickLsu(pickLsu)
);

`default_nettype wire

// File: verif/mipsTb.sv
`default_nettype none

module mipsTb;
	import mipsPkg::*;

	localparam logic [31:0] resetPc = 32'h40;
	localparam int nEntries = 24;
	localparam int memWords = 256;
	localparam int limitCycles = 16 + 200 * nEntries;

	typedef struct packed {
		logic [31:0] word;
		logic        runs;      // Retires on the taken path
		logic        writes;    // Expected grfWe
		logic [4:0]  dest;
		logic [31:0] value;
	} progEntryS;

	logic        clk;
	logic        arstN;
	busReqS      busReq;
	logic        busReqValid;
	logic        busAck;
	logic [31:0] busRdata;
	logic        grfWe;
	logic [4:0]  grfAddr;
	logic [31:0] grfWdata;
	logic [31:0] wbInstAddr;

	logic [31:0] mem [memWords];
	logic [31:0] rng;
	logic [1:0]  ackWait;
	logic [31:0] lastWbAddr;
	logic        seenReq;
	int          postReset;
	int          errors;
	int          checks;
	int          retireIdx;
	int          wbIdx;
	logic [31:0] retireExp [$];
	logic [4:0]  wbRegExp [$];
	logic [31:0] wbValExp [$];

	// Program at resetPc, one word per entry
	progEntryS prog [nEntries] = '{
		'{32'h3c011234, 1'b1, 1'b1, 5'd1,  32'h12340000},    // lui   $1, 0x1234
		'{32'h34218765, 1'b1, 1'b1, 5'd1,  32'h12348765},    // ori   $1, $1, 0x8765
		'{32'h2402fffd, 1'b1, 1'b1, 5'd2,  32'hfffffffd},    // addiu $2, $0, -3
		'{32'h00221821, 1'b1, 1'b1, 5'd3,  32'h12348762},    // addu  $3, $1, $2
		'{32'h00222023, 1'b1, 1'b1, 5'd4,  32'h12348768},    // subu  $4, $1, $2
		'{32'h00622824, 1'b1, 1'b1, 5'd5,  32'h12348760},    // and   $5, $3, $2
		'{32'h00233025, 1'b1, 1'b1, 5'd6,  32'h12348767},    // or    $6, $1, $3
		'{32'h0041382a, 1'b1, 1'b1, 5'd7,  32'h00000001},    // slt   $7, $2, $1
		'{32'h0022402a, 1'b1, 1'b1, 5'd8,  32'h00000000},    // slt   $8, $1, $2
		'{32'h34090200, 1'b1, 1'b1, 5'd9,  32'h00000200},    // ori   $9, $0, 0x200
		'{32'had230004, 1'b1, 1'b0, 5'd0,  32'h00000000},    // sw    $3, 4($9)
		'{32'h8d2a0004, 1'b1, 1'b1, 5'd10, 32'h12348762},    // lw    $10, 4($9)
		'{32'h24200005, 1'b1, 1'b0, 5'd0,  32'h00000000},    // addiu $0, $1, 5
		'{32'h000a5821, 1'b1, 1'b1, 5'd11, 32'h12348762},    // addu  $11, $0, $10
		'{32'h106a0002, 1'b1, 1'b0, 5'd0,  32'h00000000},    // beq   $3, $10, +2
		'{32'h240c0001, 1'b0, 1'b0, 5'd0,  32'h00000000},
		'{32'h240d0002, 1'b0, 1'b0, 5'd0,  32'h00000000},
		'{32'h146a0001, 1'b1, 1'b0, 5'd0,  32'h00000000},    // bne   $3, $10, +1
		'{32'had210008, 1'b1, 1'b0, 5'd0,  32'h00000000},    // sw    $1, 8($9)
		'{32'h08000025, 1'b1, 1'b0, 5'd0,  32'h00000000},    // j     0x94
		'{32'h240e0007, 1'b0, 1'b0, 5'd0,  32'h00000000},
		'{32'h8d2f0008, 1'b1, 1'b1, 5'd15, 32'h12348765},    // lw    $15, 8($9)
		'{32'h00018023, 1'b1, 1'b1, 5'd16, 32'hedcb789b},    // subu  $16, $0, $1
		'{32'h08000027, 1'b1, 1'b0, 5'd0,  32'h00000000}     // j     self, halt
	};

	mips #(.resetPc(resetPc)) i_mips (
		.clk(clk), .arstN(arstN),
		.busReq(busReq), .busReqValid(busReqValid), .busAck(busAck), .busRdata(busRdata),
		.grfWe(grfWe), .grfAddr(grfAddr), .grfWdata(grfWdata), .wbInstAddr(wbInstAddr)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Memory model, four-phase with 0 to 3 cycles of ack delay
	always @(posedge clk) begin
		if (!arstN) begin
			busAck   <= 1'b0;
			busRdata <= 32'd0;
		end else if (busAck) begin
			if (!busReqValid) begin
				busAck <= 1'b0;
			end
		end else if (busReqValid) begin
			if (ackWait == 2'd0) begin
				busAck <= 1'b1;
				if (busReq.write) begin
					mem[busReq.addr[9:2]] <= busReq.wdata;
				end else begin
					busRdata <= mem[busReq.addr[9:2]];
				end
				rng = xorshift(rng);
				ackWait <= rng[1:0];    // Delay of the next access
			end else begin
				ackWait <= ackWait - 2'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitor of reset, retirement order and write-back
	always @(negedge clk) begin
		if (!arstN || postReset == 0) begin
			assert (!busReqValid && !grfWe) else begin
				errors++;
				$display("Bus valid or register write seen during or right after reset");
			end
		end
		if (arstN) begin
			postReset++;
			if (busReqValid && !seenReq) begin
				seenReq = 1'b1;
				checks++;
				assert (busReq.addr == resetPc && !busReq.write) else begin
					errors++;
					$display("FAIL busReq.addr: got %h expected %h", busReq.addr, resetPc);
				end
			end
			if (wbInstAddr != lastWbAddr) begin
				lastWbAddr = wbInstAddr;
				assert (retireIdx < retireExp.size()) else begin
					errors++;
					$display("Instruction at %h retired after the program ended", wbInstAddr);
				end
				if (retireIdx < retireExp.size()) begin
					checks++;
					assert (wbInstAddr == retireExp[retireIdx]) else begin
						errors++;
						$display("FAIL wbInstAddr: got %h expected %h",
							wbInstAddr, retireExp[retireIdx]);
					end
					retireIdx++;
				end
			end
			if (grfWe) begin
				assert (wbIdx < wbRegExp.size()) else begin
					errors++;
					$display("Register %0d written with no write-back expected", grfAddr);
				end
				if (wbIdx < wbRegExp.size()) begin
					checks++;
					assert (grfAddr == wbRegExp[wbIdx]) else begin
						errors++;
						$display("FAIL grfAddr: got %h expected %h", grfAddr, wbRegExp[wbIdx]);
					end
					assert (grfWdata == wbValExp[wbIdx]) else begin
						errors++;
						$display("FAIL grfWdata: got %h expected %h", grfWdata, wbValExp[wbIdx]);
					end
					wbIdx++;
				end
			end
		end
	end

	initial begin
		clk        = 1'b0;
		arstN      = 1'b0;
		busAck     = 1'b0;
		busRdata   = 32'd0;
		rng        = 32'hcd75;
		ackWait    = 2'd0;
		lastWbAddr = 32'd0;
		seenReq    = 1'b0;
		postReset  = 0;
		errors     = 0;
		checks     = 0;
		retireIdx  = 0;
		wbIdx      = 0;
		for (int k = 0; k < memWords; k++) begin
			mem[k] = k * 32'h9e3779b9 + 32'h01234567;
		end
		for (int n = 0; n < nEntries; n++) begin
			mem[resetPc[9:2] + n] = prog[n].word;
			if (prog[n].runs) begin
				retireExp.push_back(resetPc + 32'(4 * n));
			end
			if (prog[n].writes) begin
				wbRegExp.push_back(prog[n].dest);
				wbValExp.push_back(prog[n].value);
			end
		end
		repeat (16) @(posedge clk);
		arstN <= 1'b1;

		while (retireIdx < retireExp.size() || wbIdx < wbRegExp.size()) begin
			@(negedge clk);
		end
		repeat (40) @(negedge clk);    // Catch stray write-backs after the halt

		// Stored words land at 0x204 and 0x208
		checks++;
		assert (mem[129] == 32'h12348762) else begin
			errors++;
			$display("FAIL mem[0x204]: got %h expected %h", mem[129], 32'h12348762);
		end
		checks++;
		assert (mem[130] == 32'h12348765) else begin
			errors++;
			$display("FAIL mem[0x208]: got %h expected %h", mem[130], 32'h12348765);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (limitCycles) @(posedge clk);
		$display("Timeout after %0d cycles, the program did not finish retiring", limitCycles);
		$display("checks %0d, errors %0d", checks, errors + 1);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/mipsPkg.sv
source/fetchUnit.sv
source/loadStoreUnit.sv
source/memArbiter.sv
source/regFile.sv
source/execUnit.sv
source/mips.sv
verif/mipsBus_props.sv
verif/mipsTb.sv

// File: Bender.yml
package:
  name: mips

sources:
  - source/mipsPkg.sv
  - source/fetchUnit.sv
  - source/loadStoreUnit.sv
  - source/memArbiter.sv
  - source/regFile.sv
  - source/execUnit.sv
  - source/mips.sv
  - target: test
    files:
      - verif/mipsBus_props.sv
      - verif/mipsTb.sv
